// File: verilog.f
tcu_pkg.sv
tcu_lzc.sv
tcu_csa_tree.sv
tcu_dot_acc.sv
tcu_norm_round.sv
tcu_apb_regs.sv
tcu_top.sv
tb_tcu.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_tcu
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

SIM  = $(BUILD_DIR)/V$(TOP)
SRCS = $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_tcu.sv
`timescale 1ns/1ps

module tb_tcu import tcu_pkg::*; ();

    localparam int NUM_HAND        = 14;
    localparam int NUM_RAND        = 12;
    localparam int NUM_ROWS        = NUM_HAND + NUM_RAND;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 40 + 100;

    logic              pclk;
    logic              rst;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;

    // Stimulus table with one row per dot product
    logic [31:0] tab_a     [NUM_ROWS];
    logic [31:0] tab_b     [NUM_ROWS];
    logic [31:0] tab_c     [NUM_ROWS];
    logic        tab_fmt   [NUM_ROWS];
    logic [7:0]  tab_scale [NUM_ROWS];
    logic [31:0] tab_exp   [NUM_ROWS];

    integer      seed;
    logic [31:0] setup_val;
    logic [31:0] rd_val;

    tcu_top dut (
        .pclk    (pclk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    // 4 ns clock
    initial begin
        pclk = 1'b0;
        forever #2 pclk = ~pclk;
    end

    // Run limit scaled to the table length
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge pclk);
        $display("Timeout: the test sequence did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $fatal(1);
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // Setup on one falling edge, access on the next, done at the rising edge after it
    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data);
        @(negedge pclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge pclk);
        penable = 1'b1;
        @(posedge pclk);
    endtask

    // Samples prdata in the setup phase as well as in the access phase
    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] early,
                            output logic [31:0] data);
        @(negedge pclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        #1;
        early = prdata;
        @(negedge pclk);
        penable = 1'b1;
        #1;
        data = prdata;
        check_value("pready", {31'b0, pready}, 32'd1);
        check_value("pslverr", {31'b0, pslverr}, 32'd0);
        @(posedge pclk);
    endtask

    task automatic bus_idle();
        @(negedge pclk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Exact sum, then either wrap to 32 bits or round to single precision
    function automatic logic [31:0] ref_result(input logic [31:0] a, input logic [31:0] b,
                                               input logic [31:0] c, input logic fmt,
                                               input logic [7:0] scale);
        longint     sum;
        longint     mag;
        longint     kept;
        longint     rem;
        longint     half;
        int         pos;
        int         sh;
        logic [7:0] e;
        logic       s;
        sum = longint'($signed(c));
        for (int i = 0; i < 4; i++) begin
            sum += longint'($signed(a[i*8 +: 8])) * longint'($signed(b[i*8 +: 8]));
        end
        if (fmt == FMT_INT) begin
            return sum[31:0];
        end
        if (sum == 0) begin
            return 32'h0000_0000;
        end
        s   = (sum < 0);
        mag = s ? -sum : sum;
        // Position of the leading one
        pos = 0;
        for (int i = 0; i < 40; i++) begin
            if (mag[i]) begin
                pos = i;
            end
        end
        e = scale + 8'(pos);
        if (pos <= 23) begin
            // Fits in the fraction without rounding
            kept = mag << (23 - pos);
        end else begin
            sh   = pos - 23;
            kept = mag >> sh;
            rem  = mag - (kept << sh);
            half = longint'(1) << (sh - 1);
            // Round to nearest with ties to an even kept value
            if (rem > half || (rem == half && kept[0])) begin
                kept++;
            end
            // 24 ones rounded up to 2^24
            if (kept == (longint'(1) << 24)) begin
                kept = kept >> 1;
                e++;
            end
        end
        return {s, e, kept[22:0]};
    endfunction

    task automatic set_row(input int r, input logic fmt, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] c,
                           input logic [7:0] scale, input logic [31:0] exp);
        tab_fmt[r]   = fmt;
        tab_a[r]     = a;
        tab_b[r]     = b;
        tab_c[r]     = c;
        tab_scale[r] = scale;
        tab_exp[r]   = exp;
    endtask

    task automatic fill_table();
        int sh;
        // Integer rows where the last two wrap at 32 bits
        set_row(0,  FMT_INT, 32'h0403_0201, 32'h0807_0605, 32'd10,        8'd0,   32'h0000_0050);
        set_row(1,  FMT_INT, 32'h027F_80FF, 32'h05FF_8003, 32'd0,         8'd0,   32'h0000_3F88);
        set_row(2,  FMT_INT, 32'h0000_0001, 32'h0000_0001, 32'h7FFF_FFFF, 8'd0,   32'h8000_0000);
        set_row(3,  FMT_INT, 32'h0000_00FF, 32'h0000_0001, 32'h8000_0000, 8'd0,   32'h7FFF_FFFF);
        // Exact fp values 1, -6, 0x10000, 0 and 3
        set_row(4,  FMT_FP,  32'h0000_0001, 32'h0000_0001, 32'd0,         8'd127, 32'h3F80_0000);
        set_row(5,  FMT_FP,  32'h0000_00FE, 32'h0000_0003, 32'd0,         8'd127, 32'hC0C0_0000);
        set_row(6,  FMT_FP,  32'h0000_0000, 32'h0000_0000, 32'h0001_0000, 8'd127, 32'h4780_0000);
        set_row(7,  FMT_FP,  32'h0000_0101, 32'h0000_FE02, 32'd0,         8'd100, 32'h0000_0000);
        set_row(8,  FMT_FP,  32'h0000_0000, 32'h0000_0000, 32'd3,         8'd160, 32'h50C0_0000);
        // Ties to even going down and up, then a value above the tie
        set_row(9,  FMT_FP,  32'h0000_0000, 32'h0000_0000, 32'h0100_0001, 8'd127, 32'h4B80_0000);
        set_row(10, FMT_FP,  32'h0000_0000, 32'h0000_0000, 32'h0100_0003, 8'd127, 32'h4B80_0002);
        set_row(11, FMT_FP,  32'h0000_0000, 32'h0000_0000, 32'h0200_0003, 8'd127, 32'h4C00_0001);
        // All-ones fraction carries into the exponent for both signs
        set_row(12, FMT_FP,  32'h0000_0000, 32'h0000_0000, 32'h01FF_FFFF, 8'd127, 32'h4C00_0000);
        set_row(13, FMT_FP,  32'h0000_0000, 32'h0000_0000, 32'hFE00_0001, 8'd127, 32'hCC00_0000);
        // Random rows alternate format and shift C to mix product and addend weight
        seed = 3704;
        for (int r = NUM_HAND; r < NUM_ROWS; r++) begin
            tab_a[r]     = $random(seed);
            tab_b[r]     = $random(seed);
            sh           = $unsigned($random(seed)) % 32;
            tab_c[r]     = $random(seed) >>> sh;
            tab_fmt[r]   = r[0];
            tab_scale[r] = 8'(64 + $unsigned($random(seed)) % 97);
            tab_exp[r]   = ref_result(tab_a[r], tab_b[r], tab_c[r], tab_fmt[r], tab_scale[r]);
        end
    endtask

    initial begin
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        fill_table();

        repeat (2) @(posedge pclk);
        @(negedge pclk);
        rst = 1'b0;

        // Reset values of mapped and unmapped addresses
        apb_read(ADDR_A, setup_val, rd_val);
        check_value("A after reset", rd_val, 32'd0);
        apb_read(ADDR_B, setup_val, rd_val);
        check_value("B after reset", rd_val, 32'd0);
        apb_read(ADDR_C, setup_val, rd_val);
        check_value("C after reset", rd_val, 32'd0);
        apb_read(ADDR_CTRL, setup_val, rd_val);
        check_value("CTRL after reset", rd_val, 32'd0);
        apb_read(ADDR_RESULT, setup_val, rd_val);
        check_value("RESULT after reset", rd_val, 32'd0);
        apb_read(ADDR_STATUS, setup_val, rd_val);
        check_value("STATUS after reset", rd_val, 32'd0);
        apb_read(8'h18, setup_val, rd_val);
        check_value("unmapped 0x18", rd_val, 32'd0);
        apb_read(8'hFC, setup_val, rd_val);
        check_value("unmapped 0xFC", rd_val, 32'd0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            apb_write(ADDR_A, tab_a[r]);
            apb_write(ADDR_B, tab_b[r]);
            apb_write(ADDR_C, tab_c[r]);
            apb_write(ADDR_CTRL, {16'b0, tab_scale[r], 6'b0, tab_fmt[r], 1'b1});
            // Done reads cleared in the cycle after the start and set two cycles after it
            apb_read(ADDR_STATUS, setup_val, rd_val);
            check_value($sformatf("STATUS cycle after start, row %0d", r), setup_val, 32'd0);
            check_value($sformatf("STATUS 2 cycles after start, row %0d", r), rd_val, 32'd1);
            apb_read(ADDR_RESULT, setup_val, rd_val);
            check_value($sformatf("RESULT row %0d", r), rd_val, tab_exp[r]);
        end

        // Still zero with live registers
        apb_read(8'h18, setup_val, rd_val);
        check_value("unmapped 0x18 at end", rd_val, 32'd0);
        bus_idle();

        $display("All tests passed");
        $finish;
    end

endmodule

// File: tcu_top.sv
`timescale 1ns/1ps

module tcu_top import tcu_pkg::*; (
    input  logic              pclk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [DATA_W-1:0] pwdata,
    output logic [DATA_W-1:0] prdata,
    output logic              pready,
    output logic              pslverr
);

    // Register block to dot stage
    logic              start_valid;
    tcu_req_t          req;
    // Dot stage to normalize stage
    logic              acc_valid;
    tcu_acc_t          acc;
    // Normalize stage back to the registers
    logic              res_valid;
    logic [DATA_W-1:0] result;

    tcu_apb_regs u_regs (
        .pclk        (pclk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .start_valid (start_valid),
        .req         (req),
        .res_valid   (res_valid),
        .result      (result)
    );

    // Stage 1, exact dot product plus C
    tcu_dot_acc u_dot (
        .clk       (pclk),
        .rst       (rst),
        .req_valid (start_valid),
        .req       (req),
        .acc_valid (acc_valid),
        .acc_out   (acc)
    );

    // Stage 2, normalize, round and format select
    tcu_norm_round u_norm (
        .clk       (pclk),
        .rst       (rst),
        .acc_valid (acc_valid),
        .acc_in    (acc),
        .res_valid (res_valid),
        .result    (result)
    );

endmodule

// File: tcu_apb_regs.sv
`timescale 1ns/1ps

module tcu_apb_regs import tcu_pkg::*; (
    input  logic              pclk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [DATA_W-1:0] pwdata,
    output logic [DATA_W-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              start_valid,
    output tcu_req_t          req,
    input  logic              res_valid,
    input  logic [DATA_W-1:0] result
);

    // Operand and control registers
    tcu_req_t          req_q;
    logic [DATA_W-1:0] result_q;
    logic              done_q;
    logic              wr_en;
    logic              ctrl_wr;

    // Write completes in the access phase
    assign wr_en   = psel & penable & pwrite;
    assign ctrl_wr = wr_en && (paddr == ADDR_CTRL);

    // Start pulse on the CTRL access cycle with bit 0 set
    assign start_valid = ctrl_wr & pwdata[0];

    // Control fields come straight from the bus in the start cycle
    always_comb begin
        req = req_q;
        if (ctrl_wr) begin
            req.fmt       = tcu_fmt_e'(pwdata[1]);
            req.scale_exp = pwdata[15:8];
        end
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            req_q    <= '0;
            result_q <= '0;
            done_q   <= 1'b0;
        end else begin
            if (wr_en && paddr == ADDR_A) begin
                req_q.a <= pwdata;
            end
            if (wr_en && paddr == ADDR_B) begin
                req_q.b <= pwdata;
            end
            if (wr_en && paddr == ADDR_C) begin
                req_q.c <= pwdata;
            end
            if (ctrl_wr) begin
                req_q.fmt       <= tcu_fmt_e'(pwdata[1]);
                req_q.scale_exp <= pwdata[15:8];
            end
            if (res_valid) begin
                result_q <= result;
                done_q   <= 1'b1;
            end
            // A new start wins over an older result arriving
            if (start_valid) begin
                done_q <= 1'b0;
            end
        end
    end

    // Read mux, RESULT and STATUS see an arriving result in the same cycle
    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                ADDR_A:      prdata = req_q.a;
                ADDR_B:      prdata = req_q.b;
                ADDR_C:      prdata = req_q.c;
                ADDR_CTRL:   prdata = {16'b0, req_q.scale_exp, 6'b0, req_q.fmt, 1'b0};
                ADDR_RESULT: prdata = res_valid ? result : result_q;
                ADDR_STATUS: prdata = {31'b0, done_q | res_valid};
                default:     prdata = '0;
            endcase
        end
    end

    // Zero wait states, no error responses
    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    // APB phase ordering from the master
    a_penable_needs_psel: assert property (@(posedge pclk) disable iff (rst) penable |-> psel)
        else $error("penable without psel");

endmodule

// File: tcu_norm_round.sv
`timescale 1ns/1ps

module tcu_norm_round import tcu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              acc_valid,
    input  tcu_acc_t          acc_in,
    output logic              res_valid,
    output logic [DATA_W-1:0] result
);

    logic                   sign;
    logic [ACC_W-1:0]       mag;
    logic [ACC_W-1:0]       norm;
    logic [LZC_W-1:0]       lz_count;
    logic                   all_zero;
    logic                   lsb;
    logic                   guard_bit;
    logic                   round_bit;
    logic                   sticky_bit;
    logic                   round_up;
    logic [FP_FRAC_W:0]     frac_rnd;
    logic [FP_EXP_W-1:0]    exp_biased;
    logic [DATA_W-1:0]      fp_res;
    logic [DATA_W-1:0]      int_res;

    // Sign and magnitude of the two's complement sum
    assign sign = acc_in.acc[ACC_W-1];
    assign mag  = sign ? -acc_in.acc : acc_in.acc;

    tcu_lzc u_lzc (
        .data_in  (mag),
        .count    (lz_count),
        .all_zero (all_zero)
    );

    // Leading one lands on the MSB, it becomes the hidden bit
    assign norm = mag << lz_count;

    // RNE on the 23 bits below the hidden one
    assign lsb        = norm[ACC_W-1-FP_FRAC_W];
    assign guard_bit  = norm[ACC_W-2-FP_FRAC_W];
    assign round_bit  = norm[ACC_W-3-FP_FRAC_W];
    assign sticky_bit = |norm[ACC_W-4-FP_FRAC_W:0];
    // Above half always up, exact half only when odd
    assign round_up   = guard_bit & (round_bit | sticky_bit | lsb);

    // Extra top bit catches the all-ones fraction overflow
    assign frac_rnd = {1'b0, norm[ACC_W-2 -: FP_FRAC_W]} + (FP_FRAC_W+1)'(round_up);

    // Leading one at bit ACC_W-1-count scales the shared exponent
    // Fraction overflow bumps it by one, low fraction bits are already zero then
    assign exp_biased = acc_in.scale_exp + FP_EXP_W'(ACC_W - 1) - FP_EXP_W'(lz_count)
                      + FP_EXP_W'(frac_rnd[FP_FRAC_W]);

    // Zero sum packs as +0
    assign fp_res = all_zero ? '0 : {sign, exp_biased, frac_rnd[FP_FRAC_W-1:0]};

    // Integer mode wraps to 32 bits
    assign int_res = acc_in.acc[DATA_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= acc_valid;
        end
    end

    // Result register, format select at the input
    always_ff @(posedge clk) begin
        if (acc_valid) begin
            result <= (acc_in.fmt == FMT_INT) ? int_res : fp_res;
        end
    end

    // Shift amount from the counter must actually normalize
    a_norm_top_bit: assert property (@(posedge clk) disable iff (rst)
        acc_valid && acc_in.fmt == FMT_FP && !all_zero |-> norm[ACC_W-1])
        else $error("normalized magnitude lost its leading one");

endmodule

// File: tcu_dot_acc.sv
`timescale 1ns/1ps

module tcu_dot_acc import tcu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    input  tcu_req_t req,
    output logic     acc_valid,
    output tcu_acc_t acc_out
);

    localparam int PROD_W = 2 * ELEM_W;

    // Products plus C, all widened to the accumulator
    logic signed [PROD_W-1:0]         prod [NUM_ELEM];
    logic [(NUM_ELEM+1)*ACC_W-1:0]    ops;
    logic [ACC_W-1:0]                 sum;

    always_comb begin
        for (int i = 0; i < NUM_ELEM; i++) begin
            // Signed 8x8 multiply, full 16-bit product
            prod[i] = $signed(req.a[i*ELEM_W +: ELEM_W]) * $signed(req.b[i*ELEM_W +: ELEM_W]);
            ops[i*ACC_W +: ACC_W] = {{(ACC_W - PROD_W){prod[i][PROD_W-1]}}, prod[i]};
        end
        // Addend C goes in the top slot
        ops[NUM_ELEM*ACC_W +: ACC_W] = {{(ACC_W - DATA_W){req.c[DATA_W-1]}}, req.c};
    end

    // Exact sum of all five terms
    tcu_csa_tree #(
        .N (NUM_ELEM + 1),
        .W (ACC_W)
    ) u_csa (
        .operands (ops),
        .sum      (sum)
    );

    // Valid bit follows the request by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= req_valid;
        end
    end

    // Payload only moves with a request
    always_ff @(posedge clk) begin
        if (req_valid) begin
            acc_out.acc       <= sum;
            acc_out.fmt       <= req.fmt;
            acc_out.scale_exp <= req.scale_exp;
        end
    end

    // Pipeline comes out of reset empty
    a_no_valid_after_rst: assert property (@(posedge clk) rst |=> !acc_valid)
        else $error("acc_valid high right after reset");

endmodule

// File: tcu_csa_tree.sv
`timescale 1ns/1ps

module tcu_csa_tree #(
    parameter int N = 5,
    parameter int W = 32
) (
    input  logic [N*W-1:0] operands,
    output logic [W-1:0]   sum
);

    // Sum and carry rows after each compressor level
    logic [W-1:0] s_row [1:N-1];
    logic [W-1:0] c_row [1:N-1];

    // First two operands seed the redundant pair
    assign s_row[1] = operands[0 +: W];
    assign c_row[1] = operands[W +: W];

    // One 3:2 compressor per remaining operand
    for (genvar i = 2; i < N; i++) begin : g_csa
        logic [W-1:0] x;
        logic [W-1:0] maj;

        assign x   = operands[i*W +: W];
        assign maj = (s_row[i-1] & c_row[i-1]) | (s_row[i-1] & x) | (c_row[i-1] & x);

        // Bitwise sum stays in place
        assign s_row[i] = s_row[i-1] ^ c_row[i-1] ^ x;
        // Majority moves up one bit, top carry drops out mod 2^W
        assign c_row[i] = {maj[W-2:0], 1'b0};
    end

    // Single carry-propagate add resolves the two rows
    assign sum = s_row[N-1] + c_row[N-1];

endmodule

// File: tcu_lzc.sv
`timescale 1ns/1ps

module tcu_lzc import tcu_pkg::*; (
    input  logic [ACC_W-1:0] data_in,
    output logic [LZC_W-1:0] count,
    output logic             all_zero
);

    // Priority encoder over the magnitude
    // Scan from LSB up so the highest set bit is the last one written
    always_comb begin
        count = LZC_W'(ACC_W);
        for (int i = 0; i < ACC_W; i++) begin
            if (data_in[i]) begin
                // Zeros above bit i
                count = LZC_W'(ACC_W - 1 - i);
            end
        end
    end

    // Zero input has no leading one, count stays at ACC_W
    assign all_zero = ~|data_in;

endmodule

// File: tcu_pkg.sv
package tcu_pkg;

    // Vector geometry
    localparam int NUM_ELEM = 4;
    localparam int ELEM_W   = 8;
    localparam int VEC_W    = NUM_ELEM * ELEM_W;

    // Signed accumulator, wide enough for C plus four full 16-bit products
    localparam int ACC_W = 34;
    // Leading-zero count range is 0 to ACC_W
    localparam int LZC_W = 6;

    // Register and result word width
    localparam int DATA_W = 32;

    // IEEE single-precision fields
    localparam int FP_EXP_W  = 8;
    localparam int FP_FRAC_W = 23;

    // APB byte offsets
    localparam int APB_AW = 8;
    localparam logic [APB_AW-1:0] ADDR_A      = 8'h00;
    localparam logic [APB_AW-1:0] ADDR_B      = 8'h04;
    localparam logic [APB_AW-1:0] ADDR_C      = 8'h08;
    localparam logic [APB_AW-1:0] ADDR_CTRL   = 8'h0C;
    localparam logic [APB_AW-1:0] ADDR_RESULT = 8'h10;
    localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h14;

    // Output format, CTRL bit 1
    typedef enum logic {
        FMT_FP  = 1'b0,
        FMT_INT = 1'b1
    } tcu_fmt_e;

    // One dot-product request, 105 bits
    typedef struct packed {
        logic [VEC_W-1:0]    a;
        logic [VEC_W-1:0]    b;
        logic [DATA_W-1:0]   c;
        tcu_fmt_e            fmt;
        logic [FP_EXP_W-1:0] scale_exp;
    } tcu_req_t;

    // Exact sum plus the fields the normalize stage still needs
    typedef struct packed {
        logic [ACC_W-1:0]    acc;
        tcu_fmt_e            fmt;
        logic [FP_EXP_W-1:0] scale_exp;
    } tcu_acc_t;

endpackage
